/* Makefile */
TOP = ethRtTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f ethRt.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF "All checks passed"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f ethRt.f

clean:
	rm -rf obj_dir

/* ethRt.f */
+incdir+include
hw/ethRtPkg.sv
hw/gmiiRxPacker.sv
hw/ethCrc32.sv
hw/gmiiTxFramer.sv
hw/ethRtInterface.sv
verif/ethRt_checker.sv
verif/ethRtTb.sv

/* hw/ethCrc32.sv */
// Ethernet FCS engine
`default_nettype none

`include "ethRt_params.svh"

module ethCrc32 import ethRtPkg::*; (
    input  logic TxClk,
    input  logic crcInit,            // Load all ones
    input  logic crcStep,            // Advance by crcByte
    input  byteT crcByte,
    output crcT  crcValue            // Raw register, not complemented
);

    crcT crcReg;

    // One byte through the reflected CRC, LSB first
    function automatic crcT crcNext(input crcT crcIn, input byteT dataIn);
        crcT  c;
        logic fb;
        c = crcIn;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ dataIn[i];
            c  = c >> 1;
            if (fb)
                c = c ^ `ETH_CRC_POLY;
        end
        return c;
    endfunction

    always_ff @(posedge TxClk) begin
        if (crcInit)
            crcReg <= '1;
        else if (crcStep)
            crcReg <= crcNext(crcReg, crcByte);
    end

    assign crcValue = crcReg;

endmodule

`default_nettype wire

/* hw/ethRtInterface.sv */
// Real-time Ethernet interface top
`default_nettype none

module ethRtInterface import ethRtPkg::*; (
    input  logic   TxClk,
    input  logic   resetActive,
    input  logic   clearErrors,
    // GMII receive
    input  logic   rxValid,
    input  byteT   rxData,
    output logic   portReady,
    // Packet engine
    input  logic   recvBusy,
    input  logic   sendBusy,
    input  respT   resp,
    output logic   recvRequest,
    output logic   recvReady,
    output wordT   recvWord,
    output logic   sendRequest,
    output rxStatT rxStat,
    input  wordT   sendWord,
    output logic   sendReady,
    // GMII transmit
    output logic   txEn,
    output byteT   txData,
    output logic   dataReady
);

    // Framer to FCS engine
    logic crcInit;
    logic crcStep;
    byteT crcByte;
    crcT  crcValue;

    gmiiRxPacker rxPacker (
        .TxClk(TxClk), .resetActive(resetActive), .clearErrors(clearErrors),
        .rxValid(rxValid), .rxData(rxData), .portReady(portReady),
        .recvBusy(recvBusy), .sendBusy(sendBusy), .resp(resp),
        .recvRequest(recvRequest), .recvReady(recvReady), .recvWord(recvWord),
        .sendRequest(sendRequest), .rxStat(rxStat)
    );

    gmiiTxFramer txFramer (
        .TxClk(TxClk), .resetActive(resetActive), .sendBusy(sendBusy),
        .byteCount(resp.byteCount),          // Response length from engine
        .sendWord(sendWord), .sendReady(sendReady),
        .txEn(txEn), .txData(txData), .dataReady(dataReady),
        .crcInit(crcInit), .crcStep(crcStep), .crcByte(crcByte), .crcValue(crcValue)
    );

    ethCrc32 fcsEngine (
        .TxClk(TxClk), .crcInit(crcInit), .crcStep(crcStep),
        .crcByte(crcByte), .crcValue(crcValue)
    );

endmodule

`default_nettype wire

/* hw/ethRtPkg.sv */
// Real-time Ethernet types
`default_nettype none

package ethRtPkg;

    typedef logic [7:0]  byteT;         // GMII data byte
    typedef logic [15:0] wordT;         // Packet engine word
    typedef logic [15:0] byteCountT;    // Byte count
    typedef logic [15:0] timeT;         // Cycle count
    typedef logic [31:0] crcT;          // Running FCS

    // Receive side FSM
    typedef enum logic [1:0] {rxIdle, rxFrame, rxWaitSend} rxStateT;

    // Transmit side FSM
    typedef enum logic [2:0] {txIdle, txPreamble, txSend, txPadding, txCrc} txStateT;

    // Response description from the packet engine
    typedef struct packed {
        logic      required;            // Frame needs an answer
        byteCountT byteCount;           // Payload bytes of the answer
    } respT;

    // Receive status, held after each frame
    typedef struct packed {
        timeT      timeReceive;         // Cycles from SFD to end of frame
        byteCountT byteCount;           // Payload bytes after SFD
        logic      notReady;            // Sticky, engine was not accepting
    } rxStatT;

endpackage

`default_nettype wire

/* hw/gmiiRxPacker.sv */
// GMII receive byte packer
`default_nettype none

`include "ethRt_params.svh"

module gmiiRxPacker import ethRtPkg::*; (
    input  logic   TxClk,
    input  logic   resetActive,
    input  logic   clearErrors,      // Clears sticky notReady
    input  logic   rxValid,
    input  byteT   rxData,
    output logic   portReady,        // Bytes count only while high
    input  logic   recvBusy,         // Engine accepts the frame
    input  logic   sendBusy,         // Engine is busy with a response
    input  respT   resp,
    output logic   recvRequest,      // Pulse on SFD
    output logic   recvReady,        // Pulse with a complete recvWord
    output wordT   recvWord,
    output logic   sendRequest,      // Pulse to start a response
    output rxStatT rxStat
);

    rxStateT   rxState;
    byteCountT byteCnt;              // Payload bytes of current frame
    timeT      frameTime;            // Running receive time
    logic [2:0] idleCnt;             // Idle cycles since last byte
    logic      byteIn;               // Byte accepted this cycle

    assign byteIn = rxValid & portReady;

    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            rxState     <= rxIdle;
            portReady   <= 1'b1;
            recvRequest <= 1'b0;
            recvReady   <= 1'b0;
            sendRequest <= 1'b0;
            rxStat      <= '0;
            byteCnt     <= '0;
            frameTime   <= '0;
            idleCnt     <= '0;
        end else begin
            // Strobes last one cycle
            recvRequest <= 1'b0;
            recvReady   <= 1'b0;
            sendRequest <= 1'b0;

            if (clearErrors)
                rxStat.notReady <= 1'b0;

            case (rxState)
                // ------------------------------
                // Hunt for SFD, preamble ignored
                // ------------------------------
                rxIdle: begin
                    portReady <= 1'b1;
                    if (byteIn && rxData == `ETH_SFD_BYTE) begin
                        recvRequest <= 1'b1;
                        byteCnt     <= '0;
                        frameTime   <= '0;
                        idleCnt     <= '0;
                        if (!recvBusy)
                            rxStat.notReady <= 1'b1;   // Engine not ready, words dropped
                        rxState <= rxFrame;
                    end
                end

                // ------------------------------
                // Pack bytes, high byte first
                // ------------------------------
                rxFrame: begin
                    frameTime <= frameTime + timeT'(1);
                    if (byteIn) begin
                        byteCnt <= byteCnt + byteCountT'(1);
                        idleCnt <= '0;
                        if (!byteCnt[0]) begin
                            recvWord[15:8] <= rxData;    // Even byte
                        end else begin
                            recvWord[7:0] <= rxData;     // Odd byte completes word
                            recvReady     <= recvBusy;
                        end
                    end else if (idleCnt == 3'(`ETH_EOF_GAP - 1)) begin
                        // End of frame, flush a lone high byte
                        if (byteCnt[0]) begin
                            recvWord[7:0] <= 8'd0;
                            recvReady     <= recvBusy;
                        end
                        rxStat.timeReceive <= frameTime + timeT'(1);   // SFD through last gap cycle
                        rxStat.byteCount   <= byteCnt;
                        if (resp.required && sendBusy) begin
                            portReady <= 1'b0;           // Block input until send done
                            rxState   <= rxWaitSend;
                        end else begin
                            sendRequest <= resp.required;
                            rxState     <= rxIdle;
                        end
                    end else begin
                        idleCnt <= idleCnt + 3'd1;
                    end
                end

                // Previous response still in flight
                rxWaitSend: begin
                    if (!sendBusy) begin
                        sendRequest <= 1'b1;
                        portReady   <= 1'b1;
                        rxState     <= rxIdle;
                    end
                end

                default: rxState <= rxIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/gmiiTxFramer.sv */
// GMII transmit framer
`default_nettype none

`include "ethRt_params.svh"

module gmiiTxFramer import ethRtPkg::*; (
    input  logic      TxClk,
    input  logic      resetActive,
    input  logic      sendBusy,      // Rising edge starts a frame
    input  byteCountT byteCount,     // Payload bytes from the engine
    input  wordT      sendWord,      // Valid the cycle after sendReady
    output logic      sendReady,     // Request next word
    output logic      txEn,
    output byteT      txData,
    output logic      dataReady,     // txData valid along with txEn
    output logic      crcInit,
    output logic      crcStep,
    output byteT      crcByte,
    input  crcT       crcValue
);

    txStateT   txState;
    logic [2:0] txCnt;               // Preamble and FCS byte index
    logic [2:0] wordPhase;           // Position within one word
    byteCountT sentCnt;              // Payload plus padding bytes sent
    byteT      hiByte;               // Second byte of current word
    logic      busyPrev;
    logic      startFrame;

    assign startFrame = sendBusy & ~busyPrev;
    assign crcInit    = (txState == txIdle) & startFrame;

    // CRC steps on the byte being loaded into txData
    always_comb begin
        crcStep = 1'b0;
        crcByte = '0;
        if (txState == txSend && wordPhase == 3'd2) begin
            crcStep = 1'b1;
            crcByte = sendWord[7:0];
        end else if (txState == txSend && wordPhase == 3'd4) begin
            crcStep = 1'b1;
            crcByte = hiByte;
        end else if (txState == txPadding) begin
            crcStep = 1'b1;                  // Zero pad byte
        end
    end

    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            txState   <= txIdle;
            txEn      <= 1'b0;
            dataReady <= 1'b1;
            sendReady <= 1'b0;
            busyPrev  <= 1'b0;
            txCnt     <= '0;
            wordPhase <= '0;
            sentCnt   <= '0;
        end else begin
            busyPrev <= sendBusy;
            case (txState)
                txIdle: begin
                    txEn      <= 1'b0;
                    dataReady <= 1'b1;
                    sendReady <= 1'b0;
                    if (startFrame) begin
                        txEn    <= 1'b1;
                        txData  <= `ETH_PREAMBLE_BYTE;   // First preamble byte
                        txCnt   <= 3'd1;
                        txState <= txPreamble;
                    end
                end

                txPreamble: begin
                    if (txCnt == 3'd7) begin
                        txData    <= `ETH_SFD_BYTE;
                        wordPhase <= '0;
                        sentCnt   <= '0;
                        txState   <= txSend;
                    end else begin
                        txData <= `ETH_PREAMBLE_BYTE;
                        txCnt  <= txCnt + 3'd1;
                    end
                end

                // ------------------------------
                // Payload, low byte first
                // ------------------------------
                txSend: begin
                    case (wordPhase)
                        3'd0: begin
                            dataReady <= 1'b0;
                            if (sentCnt == byteCount) begin
                                txCnt   <= '0;
                                txState <= (sentCnt < byteCountT'(`ETH_MIN_DATA)) ?
                                           txPadding : txCrc;
                            end else begin
                                sendReady <= 1'b1;       // Ask for next word
                                wordPhase <= 3'd1;
                            end
                        end
                        3'd1: begin
                            sendReady <= 1'b0;           // Word arrives next cycle
                            wordPhase <= 3'd2;
                        end
                        3'd2: begin
                            txData    <= sendWord[7:0];
                            hiByte    <= sendWord[15:8];
                            dataReady <= 1'b1;
                            sentCnt   <= sentCnt + byteCountT'(1);
                            wordPhase <= 3'd3;
                        end
                        3'd3: begin
                            dataReady <= 1'b0;
                            wordPhase <= (sentCnt == byteCount) ? 3'd0 : 3'd4;  // Odd count
                        end
                        3'd4: begin
                            txData    <= hiByte;
                            dataReady <= 1'b1;
                            sentCnt   <= sentCnt + byteCountT'(1);
                            wordPhase <= 3'd0;
                        end
                        default: wordPhase <= 3'd0;
                    endcase
                end

                // Zero fill up to the minimum frame
                txPadding: begin
                    txData    <= 8'd0;
                    dataReady <= 1'b1;
                    sentCnt   <= sentCnt + byteCountT'(1);
                    if (sentCnt == byteCountT'(`ETH_MIN_DATA - 1))
                        txState <= txCrc;
                end

                // ------------------------------
                // FCS, complemented, low byte first
                // ------------------------------
                txCrc: begin
                    dataReady <= 1'b1;
                    if (txCnt == 3'd4) begin
                        txEn    <= 1'b0;                 // Frame done
                        txState <= txIdle;
                    end else begin
                        txData <= ~crcValue[{txCnt[1:0], 3'b000} +: 8];
                        txCnt  <= txCnt + 3'd1;
                    end
                end

                default: txState <= txIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* include/ethRt_params.svh */
// Real-time Ethernet constants
`ifndef ETH_RT_PARAMS_SVH
`define ETH_RT_PARAMS_SVH

// ------------------------------
// Frame delimiters
// ------------------------------

`define ETH_PREAMBLE_BYTE 8'h55     // Seven of these open every frame
`define ETH_SFD_BYTE      8'hD5     // Start-of-frame delimiter

// ------------------------------
// Frame sizes and timing
// ------------------------------

// Minimum bytes before the FCS (64 byte frame minus 4 FCS bytes)
`define ETH_MIN_DATA      60

// Idle rxValid cycles that close a received frame
`define ETH_EOF_GAP       2

// ------------------------------
// FCS
// ------------------------------

`define ETH_CRC_POLY      32'hEDB88320   // Reflected IEEE 802.3 polynomial

`endif

/* verif/ethRtTb.sv */
// Real-time Ethernet testbench
`default_nettype none

`include "ethRt_params.svh"

module ethRtTb import ethRtPkg::*; ();

    typedef struct packed {
        logic [15:0] rxLen;       // Received payload bytes
        logic        required;    // Engine answers the frame
        logic        busyHeld;    // recvBusy level
        logic        backToBack;  // Second frame follows at once
        logic [15:0] respLen;     // Response payload bytes, even
    } rowT;

    localparam int NumRows = 6;

    logic TxClk, resetActive, clearErrors, rxValid, recvBusy, sendBusy;
    byteT rxData;
    respT resp;
    wordT sendWord;
    logic portReady, recvRequest, recvReady, sendRequest, sendReady, txEn, dataReady;
    wordT recvWord;
    rxStatT rxStat;
    byteT txData;

    rowT  frameTable [NumRows];
    wordT expWords[$];
    wordT gotWords[$];
    byteT txBytes[$];
    int   errCount, checkCount, recvReqCnt, sendReqCnt, txFrames, wordIdx, blockCnt;
    logic txPrev;
    logic [31:0] lfsrState;
    logic [15:0] curRespLen;

    ethRtInterface uut (
        .TxClk(TxClk), .resetActive(resetActive), .clearErrors(clearErrors),
        .rxValid(rxValid), .rxData(rxData), .portReady(portReady),
        .recvBusy(recvBusy), .sendBusy(sendBusy), .resp(resp),
        .recvRequest(recvRequest), .recvReady(recvReady), .recvWord(recvWord),
        .sendRequest(sendRequest), .rxStat(rxStat), .sendWord(sendWord),
        .sendReady(sendReady), .txEn(txEn), .txData(txData), .dataReady(dataReady)
    );

    initial begin
        TxClk = 1'b0;
        forever #5 TxClk = ~TxClk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Galois taps
    endfunction

    task automatic nextRandomByte(output byteT b);
        for (int i = 0; i < 8; i++) begin
            b[i]      = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Response payload byte j, as the engine model serves it
    function automatic byteT payloadByte(input int j);
        return 8'(j * 7 + 3);
    endfunction

    // IEEE 802.3 CRC, reflected, one byte LSB first
    function automatic logic [31:0] referenceCrcStep(input logic [31:0] c, input byteT b);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++)
            r = (r[0] ^ b[i]) ? ((r >> 1) ^ `ETH_CRC_POLY) : (r >> 1);
        return r;
    endfunction

    // Whole frame against preamble, payload, padding and FCS
    task automatic checkTxFrame();
        byteT exp[$];
        byteT b;
        logic [31:0] crc;
        int dataLen;
        crc     = 32'hFFFFFFFF;
        dataLen = (int'(curRespLen) < `ETH_MIN_DATA) ? `ETH_MIN_DATA : int'(curRespLen);
        for (int i = 0; i < 7; i++)
            exp.push_back(`ETH_PREAMBLE_BYTE);
        exp.push_back(`ETH_SFD_BYTE);
        for (int j = 0; j < dataLen; j++) begin
            b   = (j < int'(curRespLen)) ? payloadByte(j) : 8'h00;   // Zero pad
            crc = referenceCrcStep(crc, b);
            exp.push_back(b);
        end
        for (int k = 0; k < 4; k++)
            exp.push_back(~crc[k*8 +: 8]);
        checkCount++;
        if (txBytes.size() != exp.size()) begin
            errCount++;
            $display("Transmitted frame has %0d bytes, %0d were due", txBytes.size(), exp.size());
        end else begin
            for (int k = 0; k < exp.size(); k++)
                compareValue($sformatf("txData[%0d]", k), 32'(txBytes[k]), 32'(exp[k]));
        end
    endtask

    // Preamble, SFD, random payload, then the end-of-frame gap
    task automatic driveFrame(input int len);
        byteT b;
        byteT hi;
        hi = 8'h00;
        for (int i = 0; i < 7; i++) begin
            @(negedge TxClk);
            rxValid = 1'b1;
            rxData  = `ETH_PREAMBLE_BYTE;
        end
        @(negedge TxClk);
        rxData = `ETH_SFD_BYTE;
        for (int i = 0; i < len; i++) begin
            nextRandomByte(b);
            @(negedge TxClk);
            rxData = b;
            if (i % 2 == 0)
                hi = b;                          // High byte first
            else
                expWords.push_back({hi, b});
        end
        if (len % 2 == 1)
            expWords.push_back({hi, 8'h00});     // Lone byte padded
        @(negedge TxClk);
        rxValid = 1'b0;
        rxData  = 8'h00;
        repeat (`ETH_EOF_GAP) @(negedge TxClk);
    endtask

    // ------------------------------
    // Packet engine model
    // ------------------------------

    initial begin
        sendBusy   = 1'b0;
        sendWord   = '0;
        recvReqCnt = 0;
        sendReqCnt = 0;
        txFrames   = 0;
        wordIdx    = 0;
        blockCnt   = 0;
        txPrev     = 1'b0;
        forever begin
            @(negedge TxClk);
            if (!resetActive) begin
                if (recvRequest) recvReqCnt++;
                if (recvReady)   gotWords.push_back(recvWord);
                if (!portReady && sendBusy) blockCnt++;      // Reception held off
                if (sendRequest) begin
                    sendReqCnt++;
                    sendBusy = 1'b1;
                    wordIdx  = 0;
                end
                if (sendReady) begin
                    sendWord = {payloadByte(2 * wordIdx + 1), payloadByte(2 * wordIdx)};
                    wordIdx++;
                end
                if (txEn && dataReady) txBytes.push_back(txData);
                if (txPrev && !txEn) begin                   // Frame finished
                    checkTxFrame();
                    txBytes.delete();
                    txFrames++;
                    sendBusy = 1'b0;
                end
                txPrev = txEn;
            end
        end
    end

    // ------------------------------
    // Watchdog
    // ------------------------------

    initial begin
        int limit;
        #1;
        limit = 20;
        for (int r = 0; r < NumRows; r++)
            limit += 4 * (int'(frameTable[r].rxLen) * (frameTable[r].backToBack ? 2 : 1)
                          + int'(frameTable[r].respLen) + 12 + 100);
        repeat (limit) @(posedge TxClk);
        $display("Timeout after %0d cycles, the run did not finish", limit);
        $display("Checks failed");
        $finish;
    end

    // Main sequence
    initial begin
        rowT row;
        int  frames, reqBase, sendBase, txBase, gotBase, blockBase;
        frameTable[0] = '{16'd15, 1'b1, 1'b1, 1'b0, 16'd10};
        frameTable[1] = '{16'd24, 1'b1, 1'b1, 1'b0, 16'd60};
        frameTable[2] = '{16'd7,  1'b0, 1'b1, 1'b0, 16'd0};
        frameTable[3] = '{16'd20, 1'b1, 1'b1, 1'b1, 16'd100};
        frameTable[4] = '{16'd12, 1'b0, 1'b0, 1'b0, 16'd0};
        frameTable[5] = '{16'd9,  1'b1, 1'b1, 1'b0, 16'd100};
        errCount    = 0;
        checkCount  = 0;
        lfsrState   = 32'd67292;
        resetActive = 1'b1;
        clearErrors = 1'b0;
        rxValid     = 1'b0;
        rxData      = '0;
        recvBusy    = 1'b1;
        resp        = '0;
        curRespLen  = '0;
        repeat (5) @(posedge TxClk);
        @(negedge TxClk);
        resetActive = 1'b0;
        compareValue("portReady", 32'(portReady), 32'd1);
        compareValue("dataReady", 32'(dataReady), 32'd1);
        compareValue("txEn", 32'(txEn), 32'd0);
        for (int r = 0; r < NumRows; r++) begin
            row = frameTable[r];
            @(negedge TxClk);
            resp       = '{required: row.required, byteCount: row.respLen};
            recvBusy   = row.busyHeld;
            curRespLen = row.respLen;
            expWords.delete();
            frames    = row.backToBack ? 2 : 1;
            reqBase   = recvReqCnt;
            sendBase  = sendReqCnt;
            txBase    = txFrames;
            gotBase   = gotWords.size();
            blockBase = blockCnt;
            driveFrame(int'(row.rxLen));
            if (row.backToBack)
                driveFrame(int'(row.rxLen));
            repeat (`ETH_EOF_GAP + 2) @(negedge TxClk);
            if (row.required)
                while (txFrames - txBase < frames || sendBusy) @(negedge TxClk);
            compareValue("recvRequest count", 32'(recvReqCnt - reqBase), 32'(frames));
            compareValue("sendRequest count", 32'(sendReqCnt - sendBase),
                         32'(row.required ? frames : 0));
            compareValue("rxStat.byteCount", 32'(rxStat.byteCount), 32'(row.rxLen));
            // Receive time spans the payload and the end-of-frame gap
            compareValue("rxStat.timeReceive", 32'(rxStat.timeReceive),
                         32'(int'(row.rxLen) + `ETH_EOF_GAP));
            compareValue("portReady blocked", 32'(blockCnt != blockBase),
                         32'(row.backToBack));
            if (row.busyHeld) begin
                compareValue("recvReady count", 32'(gotWords.size() - gotBase),
                             32'(expWords.size()));
                for (int k = 0; k < expWords.size() && gotBase + k < gotWords.size(); k++)
                    compareValue("recvWord", 32'(gotWords[gotBase + k]), 32'(expWords[k]));
            end else begin
                compareValue("recvReady count", 32'(gotWords.size() - gotBase), 32'd0);
                compareValue("rxStat.notReady", 32'(rxStat.notReady), 32'd1);
                @(negedge TxClk);
                clearErrors = 1'b1;
                @(negedge TxClk);
                clearErrors = 1'b0;
                @(negedge TxClk);
                compareValue("rxStat.notReady", 32'(rxStat.notReady), 32'd0);
            end
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ethRt_checker.sv */
// Ethernet interface protocol checker
`default_nettype none

`include "ethRt_params.svh"

module ethRt_checker import ethRtPkg::*; (
    input wire logic TxClk,
    input wire logic resetActive,
    input wire logic recvReady,
    input wire logic recvRequest,
    input wire logic sendRequest,
    input wire logic sendBusy,
    input wire logic txEn,
    input wire logic dataReady
);

    byteCountT txByteCnt;            // Bytes moved in the current txEn window

    always_ff @(posedge TxClk) begin
        if (resetActive || !txEn)
            txByteCnt <= '0;
        else if (dataReady)
            txByteCnt <= txByteCnt + byteCountT'(1);
    end

    // ------------------------------
    // Receive strobes
    // ------------------------------

    recvReadyPulse: assert property (@(posedge TxClk) disable iff (resetActive)
        recvReady |=> !recvReady)
        else $error("recvReady high for two cycles");

    recvRequestPulse: assert property (@(posedge TxClk) disable iff (resetActive)
        recvRequest |=> !recvRequest)
        else $error("recvRequest high for two cycles");

    // ------------------------------
    // Transmit framing
    // ------------------------------

    // Preamble, SFD, minimum data and FCS all inside one txEn window
    txEnToFcs: assert property (@(posedge TxClk) disable iff (resetActive)
        $fell(txEn) |-> txByteCnt >= byteCountT'(8 + `ETH_MIN_DATA + 4))
        else $error("txEn fell before the last FCS byte");

    txEnStart: assert property (@(posedge TxClk) disable iff (resetActive)
        $rose(txEn) |-> sendBusy)   // Frame only inside a send window
        else $error("txEn rose without sendBusy");

    // Request only issued from an idle engine
    sendRequestIdle: assert property (@(posedge TxClk) disable iff (resetActive)
        sendRequest |-> !$past(sendBusy))
        else $error("sendRequest while sendBusy high");

endmodule

bind ethRtInterface ethRt_checker protoCheck (
    .TxClk(TxClk), .resetActive(resetActive), .recvReady(recvReady),
    .recvRequest(recvRequest), .sendRequest(sendRequest), .sendBusy(sendBusy),
    .txEn(txEn), .dataReady(dataReady)
);

`default_nettype wire
